/* hw/rs_pkg.sv */
package rs_pkg;

  localparam int word_w    = 32;
  localparam int reg_count = 16;

  typedef logic signed [word_w-1:0] word_t;
  typedef logic [3:0]               reg_addr_t;
  typedef logic [3:0]               tag_t;

  // tag 0 means the value sits in the register file
  localparam tag_t tag_none = 4'd0;

  localparam int add_entries  = 4;
  localparam int add_tag_base = 1; // tags 1..4
  localparam int mul_entries  = 2;
  localparam int mul_tag_base = 8; // tags 8..9

  localparam int add_cycles = 1;
  localparam int mul_cycles = 16;

  typedef enum logic [2:0] {
    op_add,
    op_mul,
    op_mv
  } op_t;

  typedef enum logic [1:0] {
    st_idle,
    st_decide,
    st_acked,
    st_release
  } issue_state_t;

endpackage

/* hw/dispatch_if.sv */
interface dispatch_if // issue control to one reservation station
  import rs_pkg::*;
();

  logic  write;
  tag_t  src1_tag;
  word_t src1_value;
  tag_t  src2_tag;
  word_t src2_value;
  logic  has_free;
  tag_t  free_tag; // lowest free entry

  modport ctrl (
    output write,
    output src1_tag,
    output src1_value,
    output src2_tag,
    output src2_value,
    input  has_free,
    input  free_tag
  );

  modport station (
    input  write,
    input  src1_tag,
    input  src1_value,
    input  src2_tag,
    input  src2_value,
    output has_free,
    output free_tag
  );

endinterface

/* hw/reg_status.sv */
module reg_status
  import rs_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  reg_addr_t rs1_addr,
  input  reg_addr_t rs2_addr,
  output tag_t      rs1_tag,
  output tag_t      rs2_tag,
  output word_t     rs1_value,
  output word_t     rs2_value,
  input  reg_addr_t read_reg,
  output tag_t      read_tag,
  output word_t     read_value,
  input  logic      rename_valid,
  input  reg_addr_t rename_reg,
  input  tag_t      rename_tag,
  input  logic      imm_valid,
  input  reg_addr_t imm_reg,
  input  word_t     imm_value,
  input  logic      cdb_valid,
  input  tag_t      cdb_tag,
  input  word_t     cdb_value
);

  tag_t  tags   [reg_count];
  word_t values [reg_count];

  logic rs1_hit;
  logic rs2_hit;

  // result on the bus this cycle counts as already written
  assign rs1_hit = cdb_valid && (tags[rs1_addr] == cdb_tag);
  assign rs2_hit = cdb_valid && (tags[rs2_addr] == cdb_tag);

  assign rs1_tag   = rs1_hit ? tag_none : tags[rs1_addr];
  assign rs1_value = rs1_hit ? cdb_value : values[rs1_addr];
  assign rs2_tag   = rs2_hit ? tag_none : tags[rs2_addr];
  assign rs2_value = rs2_hit ? cdb_value : values[rs2_addr];

  assign read_tag   = tags[read_reg];
  assign read_value = values[read_reg];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < reg_count; i++) begin
        tags[i]   <= tag_none;
        values[i] <= '0;
      end
    end else begin
      if (cdb_valid) begin
        for (int i = 0; i < reg_count; i++) begin
          // only if no younger producer took the register
          if (tags[i] == cdb_tag) begin
            tags[i]   <= tag_none;
            values[i] <= cdb_value;
          end
        end
      end
      // later writes win over the broadcast
      if (rename_valid)
        tags[rename_reg] <= rename_tag;
      if (imm_valid) begin
        tags[imm_reg]   <= tag_none;
        values[imm_reg] <= imm_value;
      end
    end
  end

endmodule

/* hw/issue_ctrl.sv */
module issue_ctrl
  import rs_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      req,
  input  op_t       op,
  input  reg_addr_t rd,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  input  logic      has_imm,
  input  word_t     imm,
  output logic      ack,
  output logic      accepted,
  output reg_addr_t rs1_addr,
  output reg_addr_t rs2_addr,
  input  tag_t      rs1_tag,
  input  tag_t      rs2_tag,
  input  word_t     rs1_value,
  input  word_t     rs2_value,
  output logic      rename_valid,
  output reg_addr_t rename_reg,
  output tag_t      rename_tag,
  output logic      imm_valid,
  output reg_addr_t imm_reg,
  output word_t     imm_value,
  dispatch_if.ctrl  add_port,
  dispatch_if.ctrl  mul_port
);

  issue_state_t state;

  logic  deciding;
  logic  to_mul;
  logic  direct_mv;
  logic  room;
  tag_t  src2_tag;
  word_t src2_value;

  assign deciding  = (state == st_decide);
  assign to_mul    = (op == op_mul);
  assign direct_mv = (op == op_mv) && has_imm; // no station needed
  assign room      = direct_mv || (to_mul ? mul_port.has_free : add_port.has_free);

  assign rs1_addr = rs1;
  assign rs2_addr = rs2;

  // second operand from imm, zero for a register move, else rs2
  always_comb begin
    if (has_imm) begin
      src2_tag   = tag_none;
      src2_value = imm;
    end else if (op == op_mv) begin
      src2_tag   = tag_none;
      src2_value = '0;
    end else begin
      src2_tag   = rs2_tag;
      src2_value = rs2_value;
    end
  end

  assign add_port.src1_tag   = rs1_tag;
  assign add_port.src1_value = rs1_value;
  assign add_port.src2_tag   = src2_tag;
  assign add_port.src2_value = src2_value;
  assign mul_port.src1_tag   = rs1_tag;
  assign mul_port.src1_value = rs1_value;
  assign mul_port.src2_tag   = src2_tag;
  assign mul_port.src2_value = src2_value;

  assign add_port.write = deciding && !to_mul && !direct_mv && add_port.has_free;
  assign mul_port.write = deciding && to_mul && mul_port.has_free;

  assign rename_valid = add_port.write || mul_port.write;
  assign rename_reg   = rd;
  assign rename_tag   = to_mul ? mul_port.free_tag : add_port.free_tag;

  assign imm_valid = deciding && direct_mv;
  assign imm_reg   = rd;
  assign imm_value = imm;

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= st_idle;
      ack      <= 1'b0;
      accepted <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (req)
            state <= st_decide;
        end
        st_decide: begin // rename and dispatch on this edge
          ack      <= 1'b1;
          accepted <= room;
          state    <= st_acked;
        end
        st_acked: begin
          if (!req)
            state <= st_release;
        end
        st_release: begin
          ack   <= 1'b0;
          state <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

/* hw/reservation_station.sv */
module reservation_station
  import rs_pkg::*;
#(
  parameter int entries     = add_entries,
  parameter int tag_base    = add_tag_base,
  parameter int exec_cycles = add_cycles,
  parameter bit is_mul      = 1'b0
) (
  input  logic        clk,
  input  logic        reset,
  dispatch_if.station disp,
  input  logic        cdb_valid,
  input  tag_t        cdb_tag,
  input  word_t       cdb_value,
  output logic        req_valid,
  output tag_t        req_tag,
  output word_t       req_value,
  input  logic        grant
);

  typedef logic [$clog2(entries)-1:0]       idx_t;
  typedef logic [$clog2(exec_cycles+1)-1:0] count_t;

  logic [entries-1:0] valid;
  logic [entries-1:0] running;
  logic [entries-1:0] finished;
  logic [entries-1:0] start;

  tag_t   op1_tag [entries];
  word_t  op1_val [entries];
  tag_t   op2_tag [entries];
  word_t  op2_val [entries];
  count_t cnt     [entries];

  idx_t free_idx;
  idx_t sel;

  always_comb begin
    free_idx = '0;
    sel      = '0;
    for (int i = entries - 1; i >= 0; i--) begin
      if (!valid[i])
        free_idx = idx_t'(i);
      if (finished[i])
        sel = idx_t'(i);
    end
  end

  assign disp.has_free = ~&valid;
  assign disp.free_tag = tag_t'(tag_base) + tag_t'(free_idx);

  // mul unit runs one entry at a time while adds all start together
  always_comb begin
    logic claimed;
    claimed = is_mul && (|running);
    start   = '0;
    for (int i = 0; i < entries; i++) begin
      if (valid[i] && !running[i] && !finished[i] && !claimed &&
          op1_tag[i] == tag_none && op2_tag[i] == tag_none) begin
        start[i] = 1'b1;
        claimed  = is_mul;
      end
    end
  end

  assign req_valid = |finished;
  assign req_tag   = tag_t'(tag_base) + tag_t'(sel);
  assign req_value = is_mul ? op1_val[sel] * op2_val[sel] // low 32 bits
                            : op1_val[sel] + op2_val[sel];

  always_ff @(posedge clk) begin
    if (reset) begin
      valid    <= '0;
      running  <= '0;
      finished <= '0;
    end else begin
      for (int i = 0; i < entries; i++) begin
        if (start[i])
          running[i] <= 1'b1;
        else if (running[i] && cnt[i] == count_t'(1)) begin
          running[i]  <= 1'b0;
          finished[i] <= 1'b1;
        end
      end
      if (grant) begin // result leaves and the entry is free again
        valid[sel]    <= 1'b0;
        finished[sel] <= 1'b0;
      end
      if (disp.write)
        valid[free_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < entries; i++) begin
      if (cdb_valid && valid[i] && op1_tag[i] == cdb_tag) begin
        op1_tag[i] <= tag_none;
        op1_val[i] <= cdb_value;
      end
      if (cdb_valid && valid[i] && op2_tag[i] == cdb_tag) begin
        op2_tag[i] <= tag_none;
        op2_val[i] <= cdb_value;
      end
      if (start[i])
        cnt[i] <= count_t'(exec_cycles);
      else if (running[i])
        cnt[i] <= cnt[i] - count_t'(1);
    end
    if (disp.write) begin
      op1_tag[free_idx] <= disp.src1_tag;
      op1_val[free_idx] <= disp.src1_value;
      op2_tag[free_idx] <= disp.src2_tag;
      op2_val[free_idx] <= disp.src2_value;
    end
  end

endmodule

/* hw/cdb_arbiter.sv */
module cdb_arbiter
  import rs_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  add_req_valid,
  input  tag_t  add_req_tag,
  input  word_t add_req_value,
  input  logic  mul_req_valid,
  input  tag_t  mul_req_tag,
  input  word_t mul_req_value,
  output logic  add_grant,
  output logic  mul_grant,
  output logic  cdb_valid,
  output tag_t  cdb_tag,
  output word_t cdb_value
);

  logic last_mul; // winner of the previous grant

  // on a tie the station that lost last time goes first
  assign mul_grant = mul_req_valid && (!add_req_valid || !last_mul);
  assign add_grant = add_req_valid && !mul_grant;

  always_ff @(posedge clk) begin
    if (reset) begin
      cdb_valid <= 1'b0;
      last_mul  <= 1'b0;
    end else begin
      cdb_valid <= add_grant || mul_grant;
      if (mul_grant)
        last_mul <= 1'b1;
      else if (add_grant)
        last_mul <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    cdb_tag   <= mul_grant ? mul_req_tag : add_req_tag;
    cdb_value <= mul_grant ? mul_req_value : add_req_value;
  end

endmodule

/* hw/rs_top.sv */
module rs_top
  import rs_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      req,
  input  op_t       op,
  input  reg_addr_t rd,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  input  logic      has_imm,
  input  word_t     imm,
  output logic      ack,
  output logic      accepted,
  input  reg_addr_t read_reg,
  output tag_t      read_tag,
  output word_t     read_value
);

  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  tag_t      rs1_tag;
  tag_t      rs2_tag;
  word_t     rs1_value;
  word_t     rs2_value;
  logic      rename_valid;
  reg_addr_t rename_reg;
  tag_t      rename_tag;
  logic      imm_valid;
  reg_addr_t imm_reg;
  word_t     imm_value;

  // common data bus
  logic  cdb_valid;
  tag_t  cdb_tag;
  word_t cdb_value;

  logic  add_req_valid;
  tag_t  add_req_tag;
  word_t add_req_value;
  logic  add_grant;
  logic  mul_req_valid;
  tag_t  mul_req_tag;
  word_t mul_req_value;
  logic  mul_grant;

  dispatch_if add_disp ();
  dispatch_if mul_disp ();

  reg_status regs (.*);

  issue_ctrl issue (
    .*,
    .add_port (add_disp.ctrl),
    .mul_port (mul_disp.ctrl)
  );

  reservation_station #(
    .entries     (add_entries),
    .tag_base    (add_tag_base),
    .exec_cycles (add_cycles),
    .is_mul      (1'b0)
  ) add_rs (
    .clk       (clk),
    .reset     (reset),
    .disp      (add_disp.station),
    .cdb_valid (cdb_valid),
    .cdb_tag   (cdb_tag),
    .cdb_value (cdb_value),
    .req_valid (add_req_valid),
    .req_tag   (add_req_tag),
    .req_value (add_req_value),
    .grant     (add_grant)
  );

  reservation_station #(
    .entries     (mul_entries),
    .tag_base    (mul_tag_base),
    .exec_cycles (mul_cycles),
    .is_mul      (1'b1)
  ) mul_rs (
    .clk       (clk),
    .reset     (reset),
    .disp      (mul_disp.station),
    .cdb_valid (cdb_valid),
    .cdb_tag   (cdb_tag),
    .cdb_value (cdb_value),
    .req_valid (mul_req_valid),
    .req_tag   (mul_req_tag),
    .req_value (mul_req_value),
    .grant     (mul_grant)
  );

  cdb_arbiter arb (.*);

endmodule

/* tb/rs_properties.sv */
module rs_properties
  import rs_pkg::*;
(
  input logic clk,
  input logic reset,
  input logic req,
  input logic ack,
  input logic accepted,
  input logic cdb_valid,
  input tag_t cdb_tag
);

  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_count = 0; // read by the testbench at the end

  ack_rise_on_req: assert property (@(posedge clk) disable iff (reset)
    $rose(ack) |-> $past(req))
    else begin
      $error("ack rose while req was low");
      fail_count++;
    end

  ack_fall_after_req: assert property (@(posedge clk) disable iff (reset)
    $fell(ack) |-> !$past(req))
    else begin
      $error("ack fell before req was dropped");
      fail_count++;
    end

  accepted_stable: assert property (@(posedge clk) disable iff (reset)
    ack && $past(ack) |-> $stable(accepted))
    else begin
      $error("accepted changed while ack was high");
      fail_count++;
    end

  // first cycle out of reset
  ack_low_after_reset: assert property (@(posedge clk)
    $fell(reset) |-> !ack)
    else begin
      $error("ack was high in the cycle after reset");
      fail_count++;
    end

  cdb_no_repeat: assert property (@(posedge clk) disable iff (reset)
    cdb_valid && $past(cdb_valid) |-> cdb_tag != $past(cdb_tag))
    else begin
      $error("common data bus carried the same tag two cycles in a row");
      fail_count++;
    end

endmodule

bind rs_top rs_properties props0 (
  .clk       (clk),
  .reset     (reset),
  .req       (req),
  .ack       (ack),
  .accepted  (accepted),
  .cdb_valid (cdb_valid),
  .cdb_tag   (cdb_tag)
);

/* tb/rs_tb.sv */
module rs_tb
  import rs_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int n_random       = 24;
  localparam int step_cycles    = 8 + mul_cycles * mul_entries;
  localparam int n_steps        = 3 * reg_count + 2 * n_random + 40; // issues and reads
  localparam int timeout_cycles = 10 + n_steps * step_cycles;

  logic      clk;
  logic      reset;
  logic      req;
  op_t       op;
  reg_addr_t rd;
  reg_addr_t rs1;
  reg_addr_t rs2;
  logic      has_imm;
  word_t     imm;
  logic      ack;
  logic      accepted;
  reg_addr_t read_reg;
  tag_t      read_tag;
  word_t     read_value;

  word_t model [reg_count]; // in-order reference state
  tag_t  ack_tag;
  word_t ack_value;
  int    seed;
  int    fails;
  int    fails_mark;
  int    test_count;
  int    pass_count;

  rs_top dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    repeat (timeout_cycles) @(posedge clk);
    $display("timeout: tests still running after %0d cycles", timeout_cycles);
    $display("Result: FAILED");
    $finish;
  end

  function automatic void apply_model(input op_t o, input reg_addr_t d, input reg_addr_t s1,
                                      input reg_addr_t s2, input logic hi, input word_t iv);
    word_t b;
    b = hi ? iv : model[s2];
    case (o)
      op_add:  model[d] = model[s1] + b;
      op_mul:  model[d] = model[s1] * b; // low 32 bits
      default: model[d] = hi ? iv : model[s1];
    endcase
  endfunction

  // four-phase handshake that updates the model on acceptance
  task automatic issue(input op_t o, input reg_addr_t d, input reg_addr_t s1,
                       input reg_addr_t s2, input logic hi, input word_t iv,
                       output logic acc);
    @(negedge clk);
    op      = o;
    rd      = d;
    rs1     = s1;
    rs2     = s2;
    has_imm = hi;
    imm     = iv;
    req     = 1'b1;
    @(negedge clk);
    while (!ack) @(negedge clk);
    ack_tag   = read_tag; // read port as seen at ack
    ack_value = read_value;
    acc       = accepted;
    req       = 1'b0;
    while (ack) @(negedge clk);
    if (acc)
      apply_model(o, d, s1, s2, hi, iv);
  endtask

  task automatic issue_retry(input op_t o, input reg_addr_t d, input reg_addr_t s1,
                             input reg_addr_t s2, input logic hi, input word_t iv);
    logic acc;
    acc = 1'b0;
    while (!acc)
      issue(o, d, s1, s2, hi, iv, acc);
  endtask

  task automatic expect_value(input string what, input word_t got, input word_t exp);
    assert (got == exp) else begin
      $display("error %0t %s: got %0d, expected %0d", $time, what, got, exp);
      fails++;
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    assert (cond) else begin
      $display("%0t %s", $time, what);
      fails++;
    end
  endtask

  task automatic wait_final(input reg_addr_t r);
    @(negedge clk);
    read_reg = r;
    #1;
    while (read_tag != tag_none) @(negedge clk);
  endtask

  task automatic check_reg(input reg_addr_t r);
    wait_final(r);
    expect_value($sformatf("r%0d read_value", r), read_value, model[r]);
  endtask

  task automatic report_test(input string name);
    test_count++;
    if (fails == fails_mark) begin
      pass_count++;
      $display("test %0d %s: ok", test_count, name);
    end else begin
      $display("test %0d %s: %0d errors", test_count, name, fails - fails_mark);
    end
    fails_mark = fails;
  endtask

  initial begin
    int        kind;
    reg_addr_t d;
    reg_addr_t s1;
    reg_addr_t s2;
    word_t     v;
    logic      acc;
    reset      = 1'b1;
    req        = 1'b0;
    op         = op_add;
    rd         = '0;
    rs1        = '0;
    rs2        = '0;
    has_imm    = 1'b0;
    imm        = '0;
    read_reg   = '0;
    seed       = 11;
    fails      = 0;
    fails_mark = 0;
    test_count = 0;
    pass_count = 0;
    for (int r = 0; r < reg_count; r++)
      model[r] = '0;
    repeat (10) @(negedge clk);
    reset = 1'b0;

    for (int r = 0; r < reg_count; r++) begin
      @(negedge clk);
      read_reg = reg_addr_t'(r);
      #1;
      expect_value($sformatf("r%0d read_tag", r), word_t'(read_tag), word_t'(tag_none));
      check_reg(reg_addr_t'(r));
    end
    report_test("reset state");

    for (int r = 0; r < reg_count; r++) begin
      v = $random(seed);
      @(negedge clk);
      read_reg = reg_addr_t'(r);
      issue_retry(op_mv, reg_addr_t'(r), 4'd0, 4'd0, 1'b1, v);
      expect_value($sformatf("r%0d read_tag at ack", r), word_t'(ack_tag), word_t'(tag_none));
      expect_value($sformatf("r%0d read_value at ack", r), ack_value, v);
    end
    report_test("immediate moves");

    for (int n = 0; n < n_random; n++) begin
      kind = $random(seed) & 3;
      d    = reg_addr_t'($random(seed));
      s1   = reg_addr_t'($random(seed));
      s2   = reg_addr_t'($random(seed));
      v    = $random(seed);
      case (kind)
        0:       issue_retry(op_add, d, s1, s2, 1'b0, 0);
        1:       issue_retry(op_add, d, s1, s2, 1'b1, v);
        2:       issue_retry(op_mul, d, s1, s2, 1'b0, 0);
        default: issue_retry(op_mv, d, s1, s2, 1'b0, 0);
      endcase
    end
    for (int r = 0; r < reg_count; r++)
      check_reg(reg_addr_t'(r));
    report_test("random mix");

    issue_retry(op_mv, 4'd1, 4'd0, 4'd0, 1'b1, 7);
    issue_retry(op_mv, 4'd2, 4'd0, 4'd0, 1'b1, -3);
    issue_retry(op_mul, 4'd3, 4'd1, 4'd2, 1'b0, 0);
    issue_retry(op_add, 4'd1, 4'd3, 4'd1, 1'b0, 0);   // overwrites a mul source
    issue_retry(op_mul, 4'd4, 4'd3, 4'd2, 1'b0, 0);   // older, slow writer of r4
    issue_retry(op_add, 4'd4, 4'd2, 4'd0, 1'b1, 100); // younger writer of r4
    issue_retry(op_mv, 4'd5, 4'd4, 4'd0, 1'b0, 0);
    issue_retry(op_add, 4'd6, 4'd1, 4'd5, 1'b0, 0);
    for (int r = 1; r <= 6; r++)
      check_reg(reg_addr_t'(r));
    repeat (mul_cycles * mul_entries) @(negedge clk); // let the old mul drain
    check_reg(4'd4);
    report_test("dependent chains");

    v = $random(seed);
    issue_retry(op_mv, 4'd1, 4'd0, 4'd0, 1'b1, v);
    v = $random(seed);
    issue_retry(op_mv, 4'd2, 4'd0, 4'd0, 1'b1, v);
    issue(op_mul, 4'd6, 4'd1, 4'd2, 1'b0, 0, acc);
    expect_true(acc, "first mul was refused");
    issue(op_mul, 4'd7, 4'd6, 4'd2, 1'b0, 0, acc);
    expect_true(acc, "second mul was refused");
    issue(op_mul, 4'd8, 4'd1, 4'd1, 1'b0, 0, acc);
    expect_true(!acc, "third mul was accepted although the mul station was full");
    wait_final(4'd6);
    issue(op_mul, 4'd8, 4'd1, 4'd1, 1'b0, 0, acc);
    expect_true(acc, "retried mul was refused after the first result was final");
    for (int r = 6; r <= 8; r++)
      check_reg(reg_addr_t'(r));
    report_test("full mul station");

    $display("tests %0d, passed %0d, failed %0d, check errors %0d, assertion failures %0d",
             test_count, pass_count, test_count - pass_count, fails,
             dut0.props0.fail_count);
    if (fails == 0 && dut0.props0.fail_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* list.f */
hw/rs_pkg.sv
hw/dispatch_if.sv
hw/reg_status.sv
hw/issue_ctrl.sv
hw/reservation_station.sv
hw/cdb_arbiter.sv
hw/rs_top.sv
tb/rs_properties.sv
tb/rs_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module rs_tb -f list.f -o rs_sim

# keep running past assertion errors so the testbench prints its verdict
out=$(./obj_dir/rs_sim +verilator+error+limit+1000)
echo "$out"

grep -qx "Result: PASSED" <<< "$out"
